// ==== rs_mem_sys.f ====
source/rs_mem_pkg.sv
source/rs_mem_select.sv
source/rs_mem_station.sv
source/mem_agu.sv
source/rs_mem_ctrl.sv
source/rs_mem_top.sv
tb/rs_mem_tb.sv

// ==== Makefile ====
# Verilator build for the memory reservation station

TOP     = rs_mem_tb
FLIST   = rs_mem_sys.f
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f $(FLIST) --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)_sim
	./$(OBJ_DIR)/$(TOP)_sim

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/rs_mem_tb.sv ====
// memory reservation station testbench
`timescale 1ns/1ps

module rs_mem_tb
    import rs_mem_pkg::*;
();

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] store_data;
        mem_func_e   func;
        logic        is_store;
        logic        misaligned;
        logic [5:0]  dest_preg;
        logic [4:0]  rob_idx;
        int          due;       // expected cycle of the request, 0 when not fixed
    } exp_t;

    logic      clock = 1'b0;
    logic      rst_n;
    dispatch_t dispatch;
    cdb_t      cdb;
    logic      flush;
    logic      mem_done;
    logic      cfg_write;
    logic [2:0] cfg_limit;
    mem_req_t  mem_req;
    logic      full;

    exp_t exp_q[$];
    int   seed = 37;
    int   cyc = 0;
    int   owed = 0;             // requests seen but not yet completed
    logic done_next = 1'b0;     // completion driven after this edge
    logic auto_done = 1'b1;
    logic no_req = 1'b0;

    rs_mem_top u_rs_mem_top (
        .clock     (clock),
        .rst_n     (rst_n),
        .dispatch  (dispatch),
        .cdb       (cdb),
        .flush     (flush),
        .mem_done  (mem_done),
        .cfg_write (cfg_write),
        .cfg_limit (cfg_limit),
        .mem_req   (mem_req),
        .full      (full)
    );

    always #5 clock = ~clock;

    always @(posedge clock) cyc <= cyc + 1;

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
        abort_run();
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        abort_run();
    endtask

    function automatic exp_t exp_head();
        exp_t e;
        e = '0;
        if (exp_q.size() != 0) e = exp_q[0];
        return e;
    endfunction

    // expected request from the address and alignment rules
    function automatic exp_t make_exp(input mem_func_e f, input logic [31:0] base,
                                      input logic [31:0] data, input logic [31:0] off,
                                      input logic [5:0] preg, input logic [4:0] rob,
                                      input int due);
        exp_t e;
        e.addr       = base + off;
        e.store_data = data;
        e.func       = f;
        e.is_store   = (f == sb) || (f == sh) || (f == sw);
        e.misaligned = ((f == lh || f == lhu || f == sh) && e.addr[0])
                    || ((f == lw || f == sw) && e.addr[1:0] != 2'b00);
        e.dest_preg  = preg;
        e.rob_idx    = rob;
        e.due        = due;
        return e;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // request checking
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (rst_n && mem_req.valid && exp_q.size() != 0) void'(exp_q.pop_front());
    end

    assert property (@(negedge clock) disable iff (!rst_n) mem_req.valid |-> exp_q.size() != 0)
        else report_error("memory request appeared with none expected");
    assert property (@(negedge clock) disable iff (!rst_n) no_req |-> !mem_req.valid)
        else report_error("memory request appeared while issue should be held");
    assert property (@(negedge clock) disable iff (!rst_n)
                     mem_req.valid |-> mem_req.addr == exp_head().addr)
        else report_mismatch("mem_req.addr", mem_req.addr, exp_head().addr);
    assert property (@(negedge clock) disable iff (!rst_n)
                     mem_req.valid |-> mem_req.store_data == exp_head().store_data)
        else report_mismatch("mem_req.store_data", mem_req.store_data, exp_head().store_data);
    assert property (@(negedge clock) disable iff (!rst_n)
                     mem_req.valid |-> mem_req.func == exp_head().func)
        else report_mismatch("mem_req.func", 32'(mem_req.func), 32'(exp_head().func));
    assert property (@(negedge clock) disable iff (!rst_n)
                     mem_req.valid |-> mem_req.is_store == exp_head().is_store)
        else report_mismatch("mem_req.is_store", 32'(mem_req.is_store), 32'(exp_head().is_store));
    assert property (@(negedge clock) disable iff (!rst_n)
                     mem_req.valid |-> mem_req.misaligned == exp_head().misaligned)
        else report_mismatch("mem_req.misaligned", 32'(mem_req.misaligned),
                             32'(exp_head().misaligned));
    assert property (@(negedge clock) disable iff (!rst_n)
                     mem_req.valid |-> mem_req.dest_preg == exp_head().dest_preg)
        else report_mismatch("mem_req.dest_preg", 32'(mem_req.dest_preg),
                             32'(exp_head().dest_preg));
    assert property (@(negedge clock) disable iff (!rst_n)
                     mem_req.valid |-> mem_req.rob_idx == exp_head().rob_idx)
        else report_mismatch("mem_req.rob_idx", 32'(mem_req.rob_idx), 32'(exp_head().rob_idx));
    assert property (@(negedge clock) disable iff (!rst_n)
                     mem_req.valid && exp_head().due != 0 |-> cyc == exp_head().due)
        else report_mismatch("mem_req cycle", 32'(cyc), 32'(exp_head().due));

    // memory side, one completion per request while auto_done is set
    always @(posedge clock) begin
        if (rst_n && mem_req.valid) owed++;
        done_next = auto_done && owed > 0;
        if (done_next) owed--;
        #1;
        mem_done = done_next;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic tick();
        @(posedge clock);
        #1;
        dispatch.valid = 1'b0;
        cdb.valid      = 1'b0;
        flush          = 1'b0;
        cfg_write      = 1'b0;
    endtask

    task automatic send_op(input mem_func_e f, input logic ar, input logic [31:0] a,
                           input logic br, input logic [31:0] b, input logic [31:0] off,
                           input logic [5:0] preg, input logic [4:0] rob);
        tick();
        dispatch.valid     = 1'b1;
        dispatch.func      = f;
        dispatch.opa_ready = ar;
        dispatch.opa.value = a;     // tag sits in the low bits when not ready
        dispatch.opb_ready = br;
        dispatch.opb.value = b;
        dispatch.offset    = off;
        dispatch.dest_preg = preg;
        dispatch.rob_idx   = rob;
    endtask

    task automatic set_cdb(input logic [5:0] preg, input logic [31:0] value);
        cdb.valid     = 1'b1;
        cdb.dest_preg = preg;
        cdb.value     = value;
    endtask

    task automatic wait_queue_empty(input string what);
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            tick();
            n++;
            if (n > 200) report_error({"timeout waiting for requests: ", what});
        end
    endtask

    task automatic wait_owed_clear();
        int n;
        n = 0;
        while (owed != 0 || done_next) begin
            tick();
            n++;
            if (n > 50) report_error("timeout waiting for completions");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed and random tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] base;
        logic [31:0] data;
        logic [31:0] off;
        mem_func_e   f;
        int          n;
        rst_n     = 1'b0;
        dispatch  = '0;
        cdb       = '0;
        flush     = 1'b0;
        mem_done  = 1'b0;
        cfg_write = 1'b0;
        cfg_limit = 3'd0;
        repeat (3) @(posedge clock);
        #1 rst_n = 1'b1;

        // ready ops, fixed latency
        for (int i = 0; i < 6; i++) begin
            base = $random(seed);
            data = $random(seed);
            off  = 32'($signed(12'($random(seed))));
            f    = mem_func_e'(3'($random(seed)));
            send_op(f, 1'b1, base, 1'b1, data, off, 6'(i + 1), 5'(i));
            exp_q.push_back(make_exp(f, base, data, off, 6'(i + 1), 5'(i), cyc + 3));
            wait_queue_empty("ready op");
        end

        // tagged base, woken later, then same-cycle dispatch and broadcast
        send_op(lw, 1'b0, 32'd9, 1'b1, 32'h0, 32'd8, 6'd10, 5'd10);
        no_req = 1'b1;
        repeat (4) tick();
        no_req = 1'b0;
        set_cdb(6'd9, 32'h0000_1000);
        exp_q.push_back(make_exp(lw, 32'h0000_1000, 32'h0, 32'd8, 6'd10, 5'd10, cyc + 3));
        wait_queue_empty("wakeup");
        send_op(sw, 1'b1, 32'h0000_2000, 1'b0, 32'd12, 32'd4, 6'd11, 5'd11);
        set_cdb(6'd12, 32'hcafe_0001);
        exp_q.push_back(make_exp(sw, 32'h0000_2000, 32'hcafe_0001, 32'd4, 6'd11, 5'd11,
                                 cyc + 3));
        wait_queue_empty("same-cycle capture");

        // fill all eight slots, then drain with one broadcast
        for (int i = 0; i < 8; i++) begin
            send_op(lbu, 1'b0, 32'd20, 1'b1, 32'h0, 32'(i), 6'(30 + i), 5'(i + 16));
        end
        tick();
        assert (full) else report_error("full did not rise with eight entries");
        set_cdb(6'd20, 32'h0004_0000);
        for (int i = 0; i < 8; i++) begin
            exp_q.push_back(make_exp(lbu, 32'h0004_0000, 32'h0, 32'(i), 6'(30 + i),
                                     5'(i + 16), 0));
        end
        wait_queue_empty("drain");
        assert (!full) else report_error("full stayed high after drain");

        // alignment of halfword and word accesses
        base = $random(seed) & 32'hffff_fff0;
        for (int i = 0; i < 4; i++) begin
            f   = (i % 2 == 0) ? lhu : sw;
            off = (i == 1) ? 32'd2 : 32'(i);    // word at 2 misses by a halfword
            send_op(f, 1'b1, base, 1'b1, 32'(i), off, 6'd40, 5'(i));
            exp_q.push_back(make_exp(f, base, 32'(i), off, 6'd40, 5'(i), cyc + 3));
            send_op(lh, 1'b1, base, 1'b1, 32'h0, 32'(i), 6'd41, 5'(i + 4));
            exp_q.push_back(make_exp(lh, base, 32'h0, 32'(i), 6'd41, 5'(i + 4), cyc + 3));
        end
        wait_queue_empty("alignment");
        wait_owed_clear();

        // limit of one holds the second op until a completion
        auto_done = 1'b0;
        tick();
        cfg_write = 1'b1;
        cfg_limit = 3'd1;
        send_op(lw, 1'b1, 32'h100, 1'b1, 32'h0, 32'h0, 6'd50, 5'd1);
        exp_q.push_back(make_exp(lw, 32'h100, 32'h0, 32'h0, 6'd50, 5'd1, cyc + 3));
        send_op(sw, 1'b1, 32'h200, 1'b1, 32'h55, 32'h4, 6'd51, 5'd2);
        exp_q.push_back(make_exp(sw, 32'h200, 32'h55, 32'h4, 6'd51, 5'd2, 0));
        n = 0;
        while (exp_q.size() == 2) begin     // first request leaves within 3 cycles
            tick();
            n++;
            if (n > 10) report_error("timeout waiting for first limited request");
        end
        no_req = 1'b1;
        repeat (5) tick();
        no_req    = 1'b0;
        auto_done = 1'b1;
        wait_queue_empty("limit release");
        wait_owed_clear();

        // flush with a full station and one request still outstanding
        auto_done = 1'b0;
        send_op(lb, 1'b1, 32'h300, 1'b1, 32'h0, 32'h1, 6'd52, 5'd3);
        exp_q.push_back(make_exp(lb, 32'h300, 32'h0, 32'h1, 6'd52, 5'd3, cyc + 3));
        wait_queue_empty("op before flush");
        for (int i = 0; i < 8; i++) begin
            send_op(lw, i[0], i[0] ? 32'h400 : 32'd60, 1'b1, 32'h0, 32'h0, 6'(i + 53),
                    5'(i + 4));
        end
        no_req = 1'b1;
        tick();
        assert (full) else report_error("full did not rise before flush");
        flush = 1'b1;
        tick();
        set_cdb(6'd60, 32'h500);
        repeat (5) tick();
        assert (!full) else report_error("full high after flush");
        no_req    = 1'b0;
        auto_done = 1'b1;
        wait_owed_clear();
        send_op(sh, 1'b1, 32'h600, 1'b1, 32'h77, 32'h2, 6'd55, 5'd6);
        exp_q.push_back(make_exp(sh, 32'h600, 32'h77, 32'h2, 6'd55, 5'd6, cyc + 3));
        wait_queue_empty("op after flush");
        repeat (3) tick();

        if (exp_q.size() != 0 || owed != 0) begin
            report_error("requests left outstanding at end of run");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== source/rs_mem_top.sv ====
// memory reservation station top
`timescale 1ns/1ps

module rs_mem_top
    import rs_mem_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  dispatch_t               dispatch,
    input  cdb_t                    cdb,
    input  logic                    flush,
    input  logic                    mem_done,
    input  logic                    cfg_write,
    input  logic [inflight_len-1:0] cfg_limit,
    output mem_req_t                mem_req,
    output logic                    full
);

    issue_t issue;          // station to address unit
    logic   issue_allow;

    rs_mem_station u_station (
        .clock       (clock),
        .rst_n       (rst_n),
        .dispatch    (dispatch),
        .cdb         (cdb),
        .flush       (flush),
        .issue_allow (issue_allow),
        .issue       (issue),
        .full        (full)
    );

    // throttles issue against outstanding memory ops
    rs_mem_ctrl u_ctrl (
        .clock       (clock),
        .rst_n       (rst_n),
        .cfg_write   (cfg_write),
        .cfg_limit   (cfg_limit),
        .issue_fire  (issue.valid),
        .req_fire    (mem_req.valid),
        .mem_done    (mem_done),
        .flush       (flush),
        .issue_allow (issue_allow)
    );

    mem_agu u_agu (
        .clock   (clock),
        .rst_n   (rst_n),
        .issue   (issue),
        .flush   (flush),
        .mem_req (mem_req)
    );

endmodule

// ==== source/rs_mem_ctrl.sv ====
// in-flight limit control
`timescale 1ns/1ps

module rs_mem_ctrl
    import rs_mem_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    cfg_write,
    input  logic [inflight_len-1:0] cfg_limit,
    input  logic                    issue_fire,
    input  logic                    req_fire,
    input  logic                    mem_done,
    input  logic                    flush,
    output logic                    issue_allow
);

    logic [inflight_len-1:0] limit;
    logic [inflight_len-1:0] count;
    logic [inflight_len:0]   pending;
    logic                    count_up;
    logic                    count_drop;

    // op in the issue register is counted one edge late, add it here
    assign pending     = {1'b0, count} + {{inflight_len{1'b0}}, issue_fire};
    assign issue_allow = pending < {1'b0, limit};

    // an op flushed out of the issue register is simply never counted
    assign count_up   = issue_fire & ~flush;
    assign count_drop = req_fire & flush;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            limit <= inflight_len'(max_inflight);
            count <= '0;
        end else begin
            if (cfg_write) begin
                limit <= (cfg_limit > max_inflight) ? inflight_len'(max_inflight) : cfg_limit;
            end
            count <= count + {{(inflight_len-1){1'b0}}, count_up}
                           - {{(inflight_len-1){1'b0}}, mem_done}
                           - {{(inflight_len-1){1'b0}}, count_drop};
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n) count <= max_inflight)
        else $error("in-flight count %0d above max", count);

    assert property (@(posedge clock) disable iff (!rst_n) mem_done |-> count != '0)
        else $error("completion with nothing in flight");

endmodule

// ==== source/mem_agu.sv ====
// memory address generation
`timescale 1ns/1ps

module mem_agu
    import rs_mem_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  issue_t   issue,
    input  logic     flush,
    output mem_req_t mem_req
);

    logic [xlen-1:0] addr;
    logic            misaligned;
    logic            is_store;
    logic            req_valid_q;
    mem_req_t        req_next;
    mem_req_t        req_q;

    assign addr     = issue.base + issue.offset;   // offset arrives sign extended
    assign is_store = issue.func inside {sb, sh, sw};

    always_comb begin
        case (issue.func)
            lh, lhu, sh: misaligned = addr[0];
            lw, sw:      misaligned = |addr[1:0];
            default:     misaligned = 1'b0;      // byte access is always aligned
        endcase
    end

    always_comb begin
        req_next.valid      = 1'b1;
        req_next.addr       = addr;
        req_next.store_data = issue.store_data;
        req_next.func       = issue.func;
        req_next.is_store   = is_store;
        req_next.misaligned = misaligned;
        req_next.dest_preg  = issue.dest_preg;
        req_next.rob_idx    = issue.rob_idx;
    end

    ////////////////////////////////////////////////////////////////////////////
    // request register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= issue.valid & ~flush;   // flush drops the op in flight
        end
    end

    always_ff @(posedge clock) begin
        if (issue.valid) begin
            req_q <= req_next;
        end
    end

    always_comb begin
        mem_req       = req_q;
        mem_req.valid = req_valid_q;
    end

endmodule

// ==== source/rs_mem_station.sv ====
// memory reservation station
`timescale 1ns/1ps

module rs_mem_station
    import rs_mem_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  dispatch_t dispatch,
    input  cdb_t      cdb,
    input  logic      flush,
    input  logic      issue_allow,
    output issue_t    issue,
    output logic      full
);

    rs_mem_entry_t          entries [rs_mem_size];
    rs_mem_entry_t          disp_entry;
    logic [rs_mem_size-1:0] busy;
    logic [rs_mem_size-1:0] ready;
    logic [rs_mem_len:0]    count;
    logic [rs_mem_len-1:0]  free_idx;
    logic [rs_mem_len-1:0]  pick_idx;
    logic                   free_any;
    logic                   pick_any;
    logic                   disp_fire;
    logic                   issue_fire;
    issue_t                 issue_next;
    issue_t                 issue_q;
    logic                   issue_valid_q;

    // a waiting operand matches when its tag is on the bus
    function automatic logic cdb_hit(input operand_u op, input cdb_t bus);
        return bus.valid && (op.tag.preg == bus.dest_preg);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // slot selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < rs_mem_size; i++) begin
            ready[i] = entries[i].opa_ready & entries[i].opb_ready;
        end
    end

    rs_mem_select u_select (
        .busy     (busy),
        .ready    (ready),
        .free_idx (free_idx),
        .free_any (free_any),
        .pick_idx (pick_idx),
        .pick_any (pick_any)
    );

    assign disp_fire  = dispatch.valid & free_any;
    assign issue_fire = pick_any & issue_allow & ~flush;
    assign full       = count[rs_mem_len];     // only reachable at rs_mem_size

    ////////////////////////////////////////////////////////////////////////////
    // dispatch and wakeup
    ////////////////////////////////////////////////////////////////////////////

    // dispatch catches a result broadcast in the same cycle
    always_comb begin
        disp_entry.func      = dispatch.func;
        disp_entry.opa_ready = dispatch.opa_ready;
        disp_entry.opa       = dispatch.opa;
        disp_entry.opb_ready = dispatch.opb_ready;
        disp_entry.opb       = dispatch.opb;
        disp_entry.offset    = dispatch.offset;
        disp_entry.dest_preg = dispatch.dest_preg;
        disp_entry.rob_idx   = dispatch.rob_idx;
        if (!dispatch.opa_ready && cdb_hit(dispatch.opa, cdb)) begin
            disp_entry.opa_ready = 1'b1;
            disp_entry.opa.value = cdb.value;
        end
        if (!dispatch.opb_ready && cdb_hit(dispatch.opb, cdb)) begin
            disp_entry.opb_ready = 1'b1;
            disp_entry.opb.value = cdb.value;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_mem_size; i++) begin
            if (busy[i] && !entries[i].opa_ready && cdb_hit(entries[i].opa, cdb)) begin
                entries[i].opa_ready <= 1'b1;
                entries[i].opa.value <= cdb.value;
            end
            if (busy[i] && !entries[i].opb_ready && cdb_hit(entries[i].opb, cdb)) begin
                entries[i].opb_ready <= 1'b1;
                entries[i].opb.value <= cdb.value;
            end
        end
        if (disp_fire) begin
            entries[free_idx] <= disp_entry;    // free slot, no wakeup conflict
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy          <= '0;
            count         <= '0;
            issue_valid_q <= 1'b0;
        end else if (flush) begin
            busy          <= '0;
            count         <= '0;
            issue_valid_q <= 1'b0;
        end else begin
            if (disp_fire) begin
                busy[free_idx] <= 1'b1;
            end
            if (issue_fire) begin
                busy[pick_idx] <= 1'b0;
            end
            count <= count + {{rs_mem_len{1'b0}}, disp_fire}
                           - {{rs_mem_len{1'b0}}, issue_fire};
            issue_valid_q <= issue_fire;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // issue register
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        issue_next.valid      = 1'b1;
        issue_next.base       = entries[pick_idx].opa.value;
        issue_next.store_data = entries[pick_idx].opb.value;
        issue_next.offset     = entries[pick_idx].offset;
        issue_next.func       = entries[pick_idx].func;
        issue_next.dest_preg  = entries[pick_idx].dest_preg;
        issue_next.rob_idx    = entries[pick_idx].rob_idx;
    end

    always_ff @(posedge clock) begin
        if (issue_fire) begin
            issue_q <= issue_next;
        end
    end

    always_comb begin
        issue       = issue_q;
        issue.valid = issue_valid_q;  // valid comes from the reset flop
    end

    // upstream must hold off while every slot is taken
    assert property (@(posedge clock) disable iff (!rst_n) dispatch.valid |-> !full)
        else $error("dispatch while station full");

    assert property (@(posedge clock) disable iff (!rst_n) count <= rs_mem_size)
        else $error("station count %0d above size", count);

endmodule

// ==== source/rs_mem_select.sv ====
// station slot priority encoders
`timescale 1ns/1ps

module rs_mem_select
    import rs_mem_pkg::*;
(
    input  logic [rs_mem_size-1:0] busy,
    input  logic [rs_mem_size-1:0] ready,
    output logic [rs_mem_len-1:0]  free_idx,
    output logic                   free_any,
    output logic [rs_mem_len-1:0]  pick_idx,
    output logic                   pick_any
);

    // lowest set bit wins
    function automatic logic [rs_mem_len-1:0] first_set(input logic [rs_mem_size-1:0] req);
        logic [rs_mem_len-1:0] idx;
        idx = '0;
        for (int i = rs_mem_size - 1; i >= 0; i--) begin
            if (req[i]) idx = rs_mem_len'(i);
        end
        return idx;
    endfunction

    always_comb begin
        logic [rs_mem_size-1:0] pick_vec;
        pick_vec = ready & busy;             // stale ready bits in free slots ignored
        free_idx = first_set(~busy);
        free_any = ~&busy;
        pick_idx = first_set(pick_vec);
        pick_any = |pick_vec;
        // the oldest-index candidate, and it really holds an op
        if (pick_any) begin
            assert (busy[pick_idx] && ((pick_vec & ((8'(1) << pick_idx) - 8'(1))) == '0))
                else $error("select picked slot %0d wrongly", pick_idx);
        end
    end

endmodule

// ==== source/rs_mem_pkg.sv ====
// memory reservation station definitions
package rs_mem_pkg;

    localparam int unsigned xlen         = 32;
    localparam int unsigned prf_len      = 6;
    localparam int unsigned rob_len      = 5;
    localparam int unsigned rs_mem_size  = 8;
    localparam int unsigned rs_mem_len   = 3;
    localparam int unsigned max_inflight = 4;
    localparam int unsigned inflight_len = 3;

    typedef enum logic [2:0] {
        lb  = 3'd0,
        lh  = 3'd1,
        lw  = 3'd2,
        lbu = 3'd3,
        lhu = 3'd4,
        sb  = 3'd5,
        sh  = 3'd6,
        sw  = 3'd7
    } mem_func_e;

    // one operand word, read as a value once ready, as a source tag before
    typedef union packed {
        logic [xlen-1:0] value;
        struct packed {
            logic [xlen-prf_len-1:0] pad;
            logic [prf_len-1:0]      preg;
        } tag;
    } operand_u;

    typedef struct packed {
        logic               valid;
        mem_func_e          func;
        logic               opa_ready;
        operand_u           opa;        // base address
        logic               opb_ready;
        operand_u           opb;        // store data
        logic [xlen-1:0]    offset;     // already sign extended
        logic [prf_len-1:0] dest_preg;
        logic [rob_len-1:0] rob_idx;
    } dispatch_t;

    typedef struct packed {
        logic               valid;
        logic [prf_len-1:0] dest_preg;
        logic [xlen-1:0]    value;
    } cdb_t;

    typedef struct packed {
        mem_func_e          func;
        logic               opa_ready;
        operand_u           opa;
        logic               opb_ready;
        operand_u           opb;
        logic [xlen-1:0]    offset;
        logic [prf_len-1:0] dest_preg;
        logic [rob_len-1:0] rob_idx;
    } rs_mem_entry_t;

    typedef struct packed {
        logic               valid;
        logic [xlen-1:0]    base;
        logic [xlen-1:0]    store_data;
        logic [xlen-1:0]    offset;
        mem_func_e          func;
        logic [prf_len-1:0] dest_preg;
        logic [rob_len-1:0] rob_idx;
    } issue_t;

    typedef struct packed {
        logic               valid;
        logic [xlen-1:0]    addr;
        logic [xlen-1:0]    store_data;
        mem_func_e          func;
        logic               is_store;
        logic               misaligned;
        logic [prf_len-1:0] dest_preg;
        logic [rob_len-1:0] rob_idx;
    } mem_req_t;

endpackage
